// ==== Makefile ====
# Verilator build and run for the road crosser

VERILATOR  ?= verilator
TOP        := road_crosser_tb
LINT_TOP   := road_crosser
FILELIST   := sources.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
SIM        := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(SIM)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/car_lane.sv ====
/* Car lane mover */

module car_lane #(
    parameter int LANE = 0
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 game_running,
    output road_pkg::lane_cars_t car_x
);

    // Step pulse for the whole lane
    logic lane_tick;

    // Columns after one step
    road_pkg::lane_cars_t next_car_x;

    // Each lane runs at its own rate
    rate_divider #(
        .PERIOD (road_pkg::LANE_PERIOD[LANE])
    ) i_lane_divider (
        .clock  (clock),
        .rst_n  (rst_n),
        .enable (game_running),
        .tick   (lane_tick)
    );

    // Advance one column to the right
    // Wrap from the right edge back to column 0
    always_comb
    begin
        for (int k = 0; k < road_pkg::CARS_PER_LANE; k++)
        begin
            if (car_x[k] == road_pkg::MAX_X)
            begin
                next_car_x[k] = '0;
            end
            else
            begin
                next_car_x[k] = car_x[k] + road_pkg::coord_t'(1);
            end
        end
    end

    // Car columns
    // All cars of the lane step on the same edge
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            // Evenly spaced across the road
            for (int k = 0; k < road_pkg::CARS_PER_LANE; k++)
            begin
                car_x[k] <= road_pkg::coord_t'(k * road_pkg::CAR_SPACING);
            end
        end
        else if (lane_tick)
        begin
            car_x <= next_car_x;
        end
    end

endmodule

// ==== logic/player_mover.sv ====
/* Player movement control */

module player_mover (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             start_game,
    input  logic             up_n,
    input  logic             down_n,
    input  logic             left_n,
    input  logic             right_n,
    output logic             game_running,
    output road_pkg::coord_t player_x,
    output road_pkg::coord_t player_y
);

    // Step pulse from the player divider
    logic player_tick;

    // Position after applying the held key
    road_pkg::coord_t next_x;
    road_pkg::coord_t next_y;

    // Idle until start, then running for good
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            game_running <= 1'b0;
        end
        else if (start_game)
        begin
            // Sticky, later start pulses change nothing
            game_running <= 1'b1;
        end
    end

    // Player pacing, only counts while running
    rate_divider #(
        .PERIOD (road_pkg::PLAYER_PERIOD)
    ) i_player_divider (
        .clock  (clock),
        .rst_n  (rst_n),
        .enable (game_running),
        .tick   (player_tick)
    );

    // Key priority up, down, left, right
    // Only the top held key is considered
    always_comb
    begin
        next_x = player_x;
        next_y = player_y;

        if (!up_n)
        begin
            // Blocked at the top row
            if (player_y != '0)
            begin
                next_y = player_y - road_pkg::coord_t'(1);
            end
        end
        else if (!down_n)
        begin
            // Blocked at the bottom row
            if (player_y != road_pkg::MAX_Y)
            begin
                next_y = player_y + road_pkg::coord_t'(1);
            end
        end
        else if (!left_n)
        begin
            // Blocked at the left column
            if (player_x != '0)
            begin
                next_x = player_x - road_pkg::coord_t'(1);
            end
        end
        else if (!right_n)
        begin
            // Blocked at the right column
            if (player_x != road_pkg::MAX_X)
            begin
                next_x = player_x + road_pkg::coord_t'(1);
            end
        end
    end

    // Position registers
    // Keys sampled on the tick cycle, new position one edge later
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            player_x <= road_pkg::PLAYER_START_X;
            player_y <= road_pkg::PLAYER_START_Y;
        end
        else if (player_tick)
        begin
            player_x <= next_x;
            player_y <= next_y;
        end
    end

endmodule

// ==== logic/rate_divider.sv ====
/* Enable gated tick divider */

module rate_divider #(
    parameter road_pkg::period_t PERIOD = road_pkg::PLAYER_PERIOD
) (
    input  logic clock,
    input  logic rst_n,
    input  logic enable,
    output logic tick
);

    // Cycle count within the current period
    road_pkg::period_t count;

    // One cycle pulse on the last count of every enabled period
    assign tick = enable && (count == PERIOD - road_pkg::period_t'(1));

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= '0;
        end
        else if (!enable)
        begin
            // Held at zero so the first tick lands PERIOD cycles after enable
            count <= '0;
        end
        else if (tick)
        begin
            count <= '0;
        end
        else
        begin
            count <= count + road_pkg::period_t'(1);
        end
    end

endmodule

// ==== logic/road_crosser.sv ====
/* Road crosser game core */

module road_crosser (
    input  logic                                         clock,
    input  logic                                         rst_n,

    // Arms the game
    input  logic                                         start_game,

    // Direction keys, pressed when low
    input  logic                                         up_n,
    input  logic                                         down_n,
    input  logic                                         left_n,
    input  logic                                         right_n,

    // Game state and positions
    output logic                                         game_running,
    output road_pkg::coord_t                             player_x,
    output road_pkg::coord_t                             player_y,

    // Car columns, one packed group per lane
    output road_pkg::lane_cars_t [road_pkg::N_LANES-1:0] car_x
);

    // Player, also owns the start state
    player_mover i_player_mover (
        .clock        (clock),
        .rst_n        (rst_n),
        .start_game   (start_game),
        .up_n         (up_n),
        .down_n       (down_n),
        .left_n       (left_n),
        .right_n      (right_n),
        .game_running (game_running),
        .player_x     (player_x),
        .player_y     (player_y)
    );

    // One mover per lane
    // Row of each car follows from the lane index
    for (genvar lane = 0; lane < road_pkg::N_LANES; lane++)
    begin : g_lane
        car_lane #(
            .LANE (lane)
        ) i_car_lane (
            .clock        (clock),
            .rst_n        (rst_n),
            .game_running (game_running),
            .car_x        (car_x[lane])
        );
    end

endmodule

// ==== logic/road_pkg.sv ====
/* Road crosser shared constants */

package road_pkg;

    // Screen coordinate, wide enough for x up to 159
    typedef logic [7:0] coord_t;

    // Divider counter width
    localparam int PERIOD_W = 8;

    // Divider period and count value
    typedef logic [PERIOD_W-1:0] period_t;

    // Playfield is 160 by 120
    localparam coord_t MAX_X = 8'd159;
    localparam coord_t MAX_Y = 8'd119;

    // Safe zone spans SAFE_Y_MIN up to the last row
    localparam coord_t SAFE_Y_MIN = 8'd100;

    // Player starts mid screen on the bottom row of the safe zone
    localparam coord_t PLAYER_START_X = 8'd80;
    localparam coord_t PLAYER_START_Y = SAFE_Y_MIN + 8'd19;

    // Lane layout
    localparam int N_LANES       = 3;
    localparam int CARS_PER_LANE = 4;

    // Car k of a lane resets to column k * CAR_SPACING
    localparam int CAR_SPACING = 40;

    // All car columns of one lane
    typedef coord_t [CARS_PER_LANE-1:0] lane_cars_t;

    // Player step rate in clock cycles
    localparam period_t PLAYER_PERIOD = 8'd4;

    // Per lane step rate, index 0 is the fastest lane
    localparam period_t [N_LANES-1:0] LANE_PERIOD = {
        period_t'(7),
        period_t'(5),
        period_t'(3)
    };

endpackage

// ==== sources.f ====
logic/road_pkg.sv
logic/rate_divider.sv
logic/player_mover.sv
logic/car_lane.sv
logic/road_crosser.sv
tests/road_crosser_tb.sv

// ==== tests/road_crosser_tb.sv ====
/* Road crosser testbench */

module road_crosser_tb;

    // Stimulus seed and phase lengths
    localparam logic [31:0] SEED = 32'h9715;
    localparam int RESET_CYCLES    = 10;
    localparam int IDLE_CYCLES     = 30;
    localparam int QUIET_CYCLES    = 40;
    localparam int EXTRA_TICKS     = 10;
    localparam int RANDOM_SEGMENTS = 300;
    localparam int MAX_HOLD        = 12;
    localparam int MARGIN          = 500;

    // Holds long enough to cross the whole field and then push on the edge
    localparam int HOLD_Y = (int'(road_pkg::MAX_Y) + EXTRA_TICKS) * int'(road_pkg::PLAYER_PERIOD);
    localparam int HOLD_X = (int'(road_pkg::MAX_X) + EXTRA_TICKS) * int'(road_pkg::PLAYER_PERIOD);

    localparam int TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES + 3 * QUIET_CYCLES + 2
        + 2 * HOLD_Y + 2 * HOLD_X + RANDOM_SEGMENTS * MAX_HOLD + MARGIN;

    // Key patterns as {up_n, down_n, left_n, right_n}
    localparam logic [3:0] KEYS_NONE = 4'b1111;
    localparam logic [3:0] KEYS_ALL  = 4'b0000;
    localparam logic [3:0] KEY_UP    = 4'b0111;
    localparam logic [3:0] KEY_DOWN  = 4'b1011;
    localparam logic [3:0] KEY_LEFT  = 4'b1101;
    localparam logic [3:0] KEY_RIGHT = 4'b1110;

    logic clock = 1'b0;
    logic rst_n = 1'b0;
    logic start_game = 1'b0;
    logic up_n = 1'b1;
    logic down_n = 1'b1;
    logic left_n = 1'b1;
    logic right_n = 1'b1;

    logic                                         game_running;
    road_pkg::coord_t                             player_x;
    road_pkg::coord_t                             player_y;
    road_pkg::lane_cars_t [road_pkg::N_LANES-1:0] car_x;

    // Reference model state
    logic                                         m_running;
    int                                           m_cycles;
    road_pkg::coord_t                             m_x;
    road_pkg::coord_t                             m_y;
    road_pkg::lane_cars_t [road_pkg::N_LANES-1:0] m_car;
    logic [road_pkg::CARS_PER_LANE-1:0]           lane0_wrapped;

    int cycle_count = 0;

    road_crosser i_road_crosser (
        .clock        (clock),
        .rst_n        (rst_n),
        .start_game   (start_game),
        .up_n         (up_n),
        .down_n       (down_n),
        .left_n       (left_n),
        .right_n      (right_n),
        .game_running (game_running),
        .player_x     (player_x),
        .player_y     (player_y),
        .car_x        (car_x)
    );

    always #5 clock = ~clock;

    task automatic fail_run();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    // Car column one step to the right, wrapping at the right edge
    function automatic road_pkg::coord_t advance_column(input road_pkg::coord_t col);
        if (col == road_pkg::MAX_X)
        begin
            return road_pkg::coord_t'(0);
        end
        return col + road_pkg::coord_t'(1);
    endfunction

    // Expected {x, y} after one player tick
    function automatic logic [15:0] next_position(
        input road_pkg::coord_t x,
        input road_pkg::coord_t y,
        input logic [3:0]       keys_n
    );
        // Highest held key wins even if it is blocked
        if (!keys_n[3])
        begin
            return (y == 0) ? {x, y} : {x, y - road_pkg::coord_t'(1)};
        end
        if (!keys_n[2])
        begin
            return (y == road_pkg::MAX_Y) ? {x, y} : {x, y + road_pkg::coord_t'(1)};
        end
        if (!keys_n[1])
        begin
            return (x == 0) ? {x, y} : {x - road_pkg::coord_t'(1), y};
        end
        if (!keys_n[0])
        begin
            return (x == road_pkg::MAX_X) ? {x, y} : {x + road_pkg::coord_t'(1), y};
        end
        return {x, y};
    endfunction

    task automatic hold_keys(input logic [3:0] keys_n, input int cycles);
        {up_n, down_n, left_n, right_n} = keys_n;
        repeat (cycles) @(negedge clock);
    endtask

    task automatic check_coord(
        input string            name,
        input road_pkg::coord_t expected,
        input road_pkg::coord_t actual
    );
        assert (actual == expected)
        else
        begin
            $display("error %s expected %h actual %h", name, expected, actual);
            fail_run();
        end
    endtask

    // Model counts edges since start, movers step on multiples of their period
    always @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            m_running <= 1'b0;
            m_cycles <= 0;
            m_x <= road_pkg::PLAYER_START_X;
            m_y <= road_pkg::PLAYER_START_Y;
            lane0_wrapped <= '0;
            for (int lane = 0; lane < road_pkg::N_LANES; lane++)
            begin
                for (int k = 0; k < road_pkg::CARS_PER_LANE; k++)
                begin
                    m_car[lane][k] <= road_pkg::coord_t'(k * road_pkg::CAR_SPACING);
                end
            end
        end
        else
        begin
            if (start_game)
            begin
                m_running <= 1'b1;
            end
            if (m_running)
            begin
                m_cycles <= m_cycles + 1;
                if ((m_cycles + 1) % int'(road_pkg::PLAYER_PERIOD) == 0)
                begin
                    {m_x, m_y} <= next_position(m_x, m_y, {up_n, down_n, left_n, right_n});
                end
                for (int lane = 0; lane < road_pkg::N_LANES; lane++)
                begin
                    if ((m_cycles + 1) % int'(road_pkg::LANE_PERIOD[lane]) == 0)
                    begin
                        for (int k = 0; k < road_pkg::CARS_PER_LANE; k++)
                        begin
                            m_car[lane][k] <= advance_column(m_car[lane][k]);
                            // Remember which lane 0 cars went round the screen
                            if (lane == 0 && m_car[lane][k] == road_pkg::MAX_X)
                            begin
                                lane0_wrapped[k] <= 1'b1;
                            end
                        end
                    end
                end
            end
        end
    end

    // DUT against model on every rising edge
    assert property (@(posedge clock) disable iff (!rst_n) game_running == m_running)
    else
    begin
        $display("error game_running expected %h actual %h",
            $sampled(m_running), $sampled(game_running));
        fail_run();
    end

    assert property (@(posedge clock) disable iff (!rst_n) player_x == m_x)
    else
    begin
        $display("error player_x expected %h actual %h", $sampled(m_x), $sampled(player_x));
        fail_run();
    end

    assert property (@(posedge clock) disable iff (!rst_n) player_y == m_y)
    else
    begin
        $display("error player_y expected %h actual %h", $sampled(m_y), $sampled(player_y));
        fail_run();
    end

    for (genvar lane = 0; lane < road_pkg::N_LANES; lane++)
    begin : g_lane_check
        assert property (@(posedge clock) disable iff (!rst_n) car_x[lane] == m_car[lane])
        else
        begin
            $display("error car_x[%0d] expected %h actual %h",
                lane, $sampled(m_car[lane]), $sampled(car_x[lane]));
            fail_run();
        end
    end

    // Run limit
    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            fail_run();
        end
    end

    initial
    begin
        logic [3:0] keys;
        int         hold;

        void'($urandom(SEED));

        repeat (RESET_CYCLES) @(negedge clock);
        rst_n = 1'b1;

        // Idle, keys pressed but game not armed
        hold_keys(KEYS_ALL, IDLE_CYCLES);

        // Single start pulse
        start_game = 1'b1;
        @(negedge clock);
        start_game = 1'b0;

        // No keys, cars pace, player stays put
        hold_keys(KEYS_NONE, QUIET_CYCLES);

        // Second pulse has no effect
        start_game = 1'b1;
        @(negedge clock);
        start_game = 1'b0;
        hold_keys(KEYS_NONE, QUIET_CYCLES);

        // Edge clamping, one direction at a time
        hold_keys(KEY_UP, HOLD_Y);
        check_coord("player_y", road_pkg::coord_t'(0), player_y);
        check_coord("player_x", road_pkg::PLAYER_START_X, player_x);
        hold_keys(KEY_LEFT, HOLD_X);
        check_coord("player_x", road_pkg::coord_t'(0), player_x);
        check_coord("player_y", road_pkg::coord_t'(0), player_y);
        hold_keys(KEY_DOWN, HOLD_Y);
        check_coord("player_y", road_pkg::MAX_Y, player_y);
        check_coord("player_x", road_pkg::coord_t'(0), player_x);
        hold_keys(KEY_RIGHT, HOLD_X);
        check_coord("player_x", road_pkg::MAX_X, player_x);
        check_coord("player_y", road_pkg::MAX_Y, player_y);
        hold_keys(KEYS_NONE, QUIET_CYCLES);

        // Random key mixes for priority, starting in a corner
        for (int i = 0; i < RANDOM_SEGMENTS; i++)
        begin
            keys = 4'($urandom());
            hold = $urandom_range(MAX_HOLD, 1);
            hold_keys(keys, hold);
        end
        hold_keys(KEYS_NONE, 1);

        // Every lane 0 car must have gone round the screen
        if (&lane0_wrapped)
        begin
            $display("No errors");
            $finish;
        end
        else
        begin
            $display("Not every car in lane 0 wrapped around the screen");
            fail_run();
        end
    end

endmodule
